// File: include/pulse_defs_defs.svh
// shared constants for the pulse sequencer; counters are 32 bits, so intervals wrap past 2^32-1
`ifndef PULSE_DEFS_DEFS_SVH
`define PULSE_DEFS_DEFS_SVH

// ==============================
// sizes
// ==============================
`define PULSE_N_CHANNELS        7      // push, inject, eject x2, gate x2, adc
`define PULSE_N_PAGES           4      // protocol pages, 2-bit page number
`define PULSE_CNT_W             32     // delay, width, interval and period count

// ==============================
// period interval, in clk100 cycles
// ==============================
`define PULSE_DEFAULT_INTERVAL  32'd1000
`define PULSE_MIN_INTERVAL      32'd100  // commits below this are raised to it

// ==============================
// register map, 64-bit words
// ==============================
`define PULSE_ADDR_CTRL         4'd0   // flags and interval
`define PULSE_ADDR_CH0          4'd1   // channels take 1..7
`define PULSE_ADDR_T0COUNT      4'd8   // read only
`define PULSE_ADDR_STAMP        4'd9   // read only

`endif

// File: hw/pulse_pkg.sv
// types for the pulse sequencer host port; reserved control flag bits must be written as zero
`include "pulse_defs_defs.svh"

package pulse_pkg;

   // one channel setting, delay in the upper word as on the old bridge
   typedef struct packed {
      logic [`PULSE_CNT_W-1:0] delay;
      logic [`PULSE_CNT_W-1:0] width;
   } delay_width_t;

   // control word, flags on top of the interval
   typedef struct packed {
      logic [27:0]             reserved;   // zero
      logic                    commit;     // load page and restart period
      logic                    view_active;  // reads return the running set
      logic [1:0]              page;
      logic [`PULSE_CNT_W-1:0] interval;
   } ctrl_word_t;

   // one host word, decoded by address
   typedef union packed {
      delay_width_t pair;   // channel addresses
      ctrl_word_t   ctrl;   // control address
   } reg_word_u;

   typedef struct packed {
      logic      req;
      logic      write;
      logic [3:0] addr;
      reg_word_u wdata;
   } host_req_t;

   typedef struct packed {
      logic        ack;
      logic [63:0] rdata;
   } host_rsp_t;

endpackage

// File: hw/protocol_regs.sv
// host must hold req fields stable until ack; channel writes land in the page of the last ctrl word
`include "pulse_defs_defs.svh"

module protocol_regs (
   input  logic                     clk100,
   input  logic                     hps_fpga_reset_n,
   input  pulse_pkg::host_req_t     host_req,
   output pulse_pkg::host_rsp_t     host_rsp,
   input  logic [31:0]              t0_count,
   input  logic [63:0]              stamp,
   output pulse_pkg::delay_width_t  active_pairs [`PULSE_N_CHANNELS],
   output logic                     commit,
   output logic [`PULSE_CNT_W-1:0]  interval
);

   localparam int CH_W = $clog2(`PULSE_N_CHANNELS);

   pulse_pkg::delay_width_t pages [`PULSE_N_PAGES][`PULSE_N_CHANNELS];
   pulse_pkg::ctrl_word_t   ctrl_q;
   logic                    ack_q;
   logic [63:0]             rdata_q;
   logic [63:0]             rd_word;
   logic                    accept;
   logic                    wr_ctrl;
   logic                    wr_ch;
   logic                    is_ch;
   logic [3:0]              ch_off;
   logic [CH_W-1:0]         ch_idx;

   // ==============================
   // address decode
   // ==============================
   assign accept  = host_req.req && !ack_q;            // first edge of a request
   assign ch_off  = host_req.addr - `PULSE_ADDR_CH0;   // wraps for addr 0
   assign ch_idx  = ch_off[CH_W-1:0];
   assign is_ch   = ch_off < 4'(`PULSE_N_CHANNELS);
   assign wr_ctrl = accept && host_req.write && host_req.addr == `PULSE_ADDR_CTRL;
   assign wr_ch   = accept && host_req.write && is_ch;

   // ==============================
   // handshake
   // ==============================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         ack_q <= 1'b0;
      end else if (accept) begin
         ack_q <= 1'b1;
      end else if (!host_req.req) begin
         ack_q <= 1'b0;                                 // host let go
      end
   end

   always_ff @(posedge clk100) begin
      if (accept) begin
         rdata_q <= rd_word;                            // held while ack is high
      end
   end

   assign host_rsp.ack   = ack_q;
   assign host_rsp.rdata = rdata_q;

   // ==============================
   // control word and commit
   // ==============================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         ctrl_q          <= '0;
         ctrl_q.interval <= `PULSE_DEFAULT_INTERVAL;
         commit          <= 1'b0;
      end else begin
         commit <= 1'b0;                                // one-cycle strobe
         if (wr_ctrl) begin
            ctrl_q <= host_req.wdata.ctrl;
            commit <= host_req.wdata.ctrl.commit;
         end
      end
   end

   assign interval = ctrl_q.interval;

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         for (int p = 0; p < `PULSE_N_PAGES; p++) begin
            for (int c = 0; c < `PULSE_N_CHANNELS; c++) begin
               pages[p][c] <= '0;
            end
         end
      end else if (wr_ch) begin
         pages[ctrl_q.page][ch_idx] <= host_req.wdata.pair;
      end
   end

   // active set follows the page named in the committing word
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         for (int c = 0; c < `PULSE_N_CHANNELS; c++) begin
            active_pairs[c] <= '0;
         end
      end else if (wr_ctrl && host_req.wdata.ctrl.commit) begin
         for (int c = 0; c < `PULSE_N_CHANNELS; c++) begin
            active_pairs[c] <= pages[host_req.wdata.ctrl.page][c];
         end
      end
   end

   // ==============================
   // read mux
   // ==============================
   always_comb begin
      rd_word = '0;
      if (is_ch) begin
         rd_word = ctrl_q.view_active ? active_pairs[ch_idx] : pages[ctrl_q.page][ch_idx];
      end else if (host_req.addr == `PULSE_ADDR_CTRL) begin
         rd_word = ctrl_q;
      end else if (host_req.addr == `PULSE_ADDR_T0COUNT) begin
         rd_word = {32'd0, t0_count};
      end else if (host_req.addr == `PULSE_ADDR_STAMP) begin
         rd_word = stamp;
      end
   end

   ack_needs_req: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      !ack_q ##1 ack_q |-> $past(host_req.req));

endmodule

// File: hw/period_timer.sv
// a new interval takes effect only on commit; the first period after reset uses the default
`include "pulse_defs_defs.svh"

module period_timer (
   input  logic                    clk100,
   input  logic                    hps_fpga_reset_n,
   input  logic                    commit,
   input  logic [`PULSE_CNT_W-1:0] interval,
   output logic [`PULSE_CNT_W-1:0] count,
   output logic                    t0,
   output logic [31:0]             t0_count,
   output logic [63:0]             stamp
);

   logic [`PULSE_CNT_W-1:0] interval_q;
   logic [`PULSE_CNT_W-1:0] interval_clamped;
   logic [63:0]             clk_cnt;
   logic                    wrap;

   assign interval_clamped = (interval < `PULSE_MIN_INTERVAL) ? `PULSE_MIN_INTERVAL : interval;
   assign wrap             = count >= interval_q - 1'b1;    // last cycle of the period

   // ==============================
   // period count and t0
   // ==============================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         interval_q <= `PULSE_DEFAULT_INTERVAL;
         count      <= '0;
         t0         <= 1'b0;
      end else if (commit) begin
         interval_q <= interval_clamped;
         count      <= '0;                      // restart, t0 lands on count 0
         t0         <= 1'b1;
      end else if (wrap) begin
         count      <= '0;
         t0         <= 1'b1;
      end else begin
         count      <= count + 1'b1;
         t0         <= 1'b0;
      end
   end

   // ==============================
   // clock counter, stamp, t0 count
   // ==============================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         clk_cnt <= '0;
      end else begin
         clk_cnt <= clk_cnt + 1'b1;             // free running
      end
   end

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         t0_count <= '0;
         stamp    <= '0;
      end else if (t0) begin
         t0_count <= t0_count + 1'b1;
         stamp    <= clk_cnt;
      end
   end

   interval_floor: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      interval_q >= `PULSE_MIN_INTERVAL);

endmodule

// File: hw/delay_channel.sv
// pin is one cycle behind the count; windows past the interval end are cut at the wrap
`include "pulse_defs_defs.svh"

module delay_channel (
   input  logic                    clk100,
   input  logic                    hps_fpga_reset_n,
   input  pulse_pkg::delay_width_t pair,
   input  logic [`PULSE_CNT_W-1:0] count,
   output logic                    pin
);

   logic                    started;
   logic [`PULSE_CNT_W-1:0] elapsed;
   logic                    in_window;

   // compare on the offset into the window so delay+width cannot overflow
   assign started   = count >= pair.delay;
   assign elapsed   = count - pair.delay;
   assign in_window = started && (elapsed < pair.width);    // false for width 0

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         pin <= 1'b0;
      end else begin
         pin <= in_window;
      end
   end

   pin_idle_after_reset: assert property (@(posedge clk100)
      !hps_fpga_reset_n |=> !pin);

endmodule

// File: hw/pulse_outputs.sv
// sequencer pins are active low; t0 is active high and delayed to line up with the pins
`include "pulse_defs_defs.svh"

module pulse_outputs (
   input  logic                         clk100,
   input  logic                         hps_fpga_reset_n,
   input  logic [`PULSE_N_CHANNELS-1:0] pins,
   input  logic                         t0_in,
   output logic                         push_n,
   output logic                         inject_n,
   output logic                         eject_n,
   output logic                         gate_n,
   output logic                         adc_n,
   output logic                         t0
);

   logic t0_d1;   // matches the channel register

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         push_n   <= 1'b1;
         inject_n <= 1'b1;
         eject_n  <= 1'b1;
         gate_n   <= 1'b1;
         adc_n    <= 1'b1;
         t0_d1    <= 1'b0;
         t0       <= 1'b0;
      end else begin
         push_n   <= ~pins[0];
         inject_n <= ~pins[1];
         eject_n  <= ~(pins[2] | pins[3]);   // two eject sectors
         gate_n   <= ~(pins[4] | pins[5]);   // two gates
         adc_n    <= ~pins[6];
         t0_d1    <= t0_in;
         t0       <= t0_d1;
      end
   end

endmodule

// File: hw/delay_generator_top.sv
// single clk100 domain; the host port must follow the four-phase req/ack handshake
`include "pulse_defs_defs.svh"

module delay_generator_top (
   input  logic                 clk100,
   input  logic                 hps_fpga_reset_n,
   input  pulse_pkg::host_req_t host_req,
   output pulse_pkg::host_rsp_t host_rsp,
   output logic                 push_n,
   output logic                 inject_n,
   output logic                 eject_n,
   output logic                 gate_n,
   output logic                 adc_n,
   output logic                 t0
);

   pulse_pkg::delay_width_t      active_pairs [`PULSE_N_CHANNELS];
   logic                         commit;
   logic [`PULSE_CNT_W-1:0]      interval;
   logic [`PULSE_CNT_W-1:0]      count;
   logic                         t0_raw;       // aligned with count 0
   logic [31:0]                  t0_count;
   logic [63:0]                  stamp;
   logic [`PULSE_N_CHANNELS-1:0] pins;

   protocol_regs protocol_regs_inst (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .host_req         (host_req),
      .host_rsp         (host_rsp),
      .t0_count         (t0_count),
      .stamp            (stamp),
      .active_pairs     (active_pairs),
      .commit           (commit),
      .interval         (interval)
   );

   period_timer period_timer_inst (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .commit           (commit),
      .interval         (interval),
      .count            (count),
      .t0               (t0_raw),
      .t0_count         (t0_count),
      .stamp            (stamp)
   );

   // ==============================
   // one compare per channel
   // ==============================
   for (genvar i = 0; i < `PULSE_N_CHANNELS; i++) begin : gen_channel
      delay_channel delay_channel_inst (
         .clk100           (clk100),
         .hps_fpga_reset_n (hps_fpga_reset_n),
         .pair             (active_pairs[i]),
         .count            (count),
         .pin              (pins[i])
      );
   end

   pulse_outputs pulse_outputs_inst (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .pins             (pins),
      .t0_in            (t0_raw),
      .push_n           (push_n),
      .inject_n         (inject_n),
      .eject_n          (eject_n),
      .gate_n           (gate_n),
      .adc_n            (adc_n),
      .t0               (t0)
   );

endmodule

// File: tests/tb_delay_generator.sv
// directed tests of the pulse sequencer; each wait gives up after its own cycle limit
`include "pulse_defs_defs.svh"

module tb_delay_generator;

   logic                 clk100 = 1'b0;
   logic                 hps_fpga_reset_n;
   pulse_pkg::host_req_t host_req;
   pulse_pkg::host_rsp_t host_rsp;
   logic                 push_n;
   logic                 inject_n;
   logic                 eject_n;
   logic                 gate_n;
   logic                 adc_n;
   logic                 t0;
   logic [31:0]          lcg_state = 32'd40072;
   logic [63:0]          model [`PULSE_N_PAGES][`PULSE_N_CHANNELS];   // expected page contents
   int                   errors = 0;
   int                   checks = 0;
   int                   cyc = 0;

   delay_generator_top delay_generator_top_inst (.*);

   always #10 clk100 = ~clk100;
   always @(posedge clk100) cyc <= cyc + 1;   // cycle stamp for period measurements

   // ==============================
   // helpers
   // ==============================
   function automatic logic [31:0] random_below(input logic [31:0] limit);
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return (lcg_state >> 8) % limit;   // low bits of an lcg are weak
   endfunction

   function automatic logic [63:0] ctrl_word(input logic do_commit, input logic view,
                                             input logic [1:0] page, input logic [31:0] interval);
      pulse_pkg::ctrl_word_t c;
      c             = '0;
      c.commit      = do_commit;
      c.view_active = view;
      c.page        = page;
      c.interval    = interval;
      return c;
   endfunction

   function automatic logic pin_value(input int sel);
      case (sel)
         0:       return push_n;
         1:       return inject_n;
         2:       return eject_n;
         3:       return gate_n;
         default: return adc_n;
      endcase
   endfunction

   task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s, got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("timeout at %0t while waiting for %s", $time, what);
   endtask

   task automatic end_test(input string name, input int errors_before);
      $display("test %s done with %0d errors", name, errors - errors_before);
   endtask

   // ==============================
   // host port, four-phase handshake
   // ==============================
   task automatic host_handshake(input logic write, input logic [3:0] addr,
                                 input logic [63:0] wdata, output logic [63:0] rdata);
      int n;
      @(posedge clk100);
      #1;
      host_req.write = write;
      host_req.addr  = addr;
      host_req.wdata = wdata;
      host_req.req   = 1'b1;
      for (n = 0; n < 50 && !host_rsp.ack; n++) begin
         @(negedge clk100);
      end
      if (!host_rsp.ack) report_timeout("ack to rise");
      rdata = host_rsp.rdata;   // valid while ack is high
      @(posedge clk100);
      #1;
      host_req.req = 1'b0;
      for (n = 0; n < 50 && host_rsp.ack; n++) begin
         @(negedge clk100);
      end
      if (host_rsp.ack) report_timeout("ack to fall");
   endtask

   task automatic host_write(input logic [3:0] addr, input logic [63:0] word);
      logic [63:0] ignored;
      host_handshake(1'b1, addr, word, ignored);
   endtask

   task automatic host_read(input logic [3:0] addr, output logic [63:0] word);
      host_handshake(1'b0, addr, 64'd0, word);
   endtask

   // ==============================
   // pin observation, sampled on the falling edge
   // ==============================
   task automatic wait_t0_rise(input int limit);
      logic last;
      logic found;
      last  = 1'b1;   // a pulse already high does not count
      found = 1'b0;
      for (int n = 0; n < limit && !found; n++) begin
         @(negedge clk100);
         found = t0 && !last;
         last  = t0;
      end
      if (!found) report_timeout("a t0 rising edge");
   endtask

   task automatic measure_period(output int period, output logic saw_low);
      int   start;
      logic last;
      wait_t0_rise(3000);
      start   = cyc;
      saw_low = 1'b0;
      last    = 1'b1;
      period  = 0;
      for (int n = 0; n < 3000 && period == 0; n++) begin
         @(negedge clk100);
         saw_low |= !(push_n & inject_n & eject_n & gate_n & adc_n);
         if (t0 && !last) period = cyc - start;
         last = t0;
      end
      if (period == 0) report_timeout("the next t0 rising edge");
   endtask

   // offset from the t0 rise to the pin fall, and how long the pin stays low
   task automatic measure_pulse(input int sel, output int offset, output int len);
      int n;
      wait_t0_rise(3000);
      offset = -1;
      len    = 0;
      for (n = 0; n < 3000; n++) begin
         if (!pin_value(sel)) begin
            if (offset < 0) offset = n;
            len++;
         end else if (offset >= 0) begin
            break;
         end
         @(negedge clk100);
      end
      if (n == 3000) report_timeout("a complete low pulse");
   endtask

   // ==============================
   // directed tests
   // ==============================
   task automatic test_reset_idle();
      int   e0;
      int   period;
      logic saw_low;
      e0 = errors;
      measure_period(period, saw_low);
      check_equal(64'(saw_low), 64'd0, "pulse pin low after reset");
      check_equal(64'(period), 64'(`PULSE_DEFAULT_INTERVAL), "default t0 period");
      end_test("reset_idle", e0);
   endtask

   task automatic test_page_readback();
      int          e0;
      int          p;
      logic [31:0] delay;
      logic [31:0] width;
      logic [63:0] word;
      e0 = errors;
      for (int k = 0; k < 2; k++) begin
         p = 2 * k;   // pages 0 and 2
         host_write(`PULSE_ADDR_CTRL, ctrl_word(1'b0, 1'b0, 2'(p), `PULSE_DEFAULT_INTERVAL));
         for (int c = 0; c < `PULSE_N_CHANNELS; c++) begin
            delay      = random_below(32'd150);
            width      = 32'd1 + random_below(32'd100);
            model[p][c] = {delay, width};
            host_write(`PULSE_ADDR_CH0 + 4'(c), model[p][c]);
         end
      end
      for (int k = 0; k < 2; k++) begin
         p = 2 * k;
         host_write(`PULSE_ADDR_CTRL, ctrl_word(1'b0, 1'b0, 2'(p), `PULSE_DEFAULT_INTERVAL));
         for (int c = 0; c < `PULSE_N_CHANNELS; c++) begin
            host_read(`PULSE_ADDR_CH0 + 4'(c), word);
            check_equal(word, model[p][c], "page readback");
         end
      end
      end_test("page_readback", e0);
   endtask

   task automatic test_commit_timing();
      int          e0;
      int          period;
      int          offset;
      int          len;
      logic        saw_low;
      logic [63:0] word;
      e0 = errors;
      host_write(`PULSE_ADDR_CTRL, ctrl_word(1'b1, 1'b0, 2'd2, 32'd400));
      measure_period(period, saw_low);
      check_equal(64'(period), 64'd400, "t0 period after commit");
      check_equal(64'(saw_low), 64'd1, "pulse pins active after commit");
      for (int s = 0; s < 2; s++) begin   // push, then inject
         measure_pulse(s, offset, len);
         check_equal(64'(offset), 64'(model[2][s][63:32]), "pulse offset from t0");
         check_equal(64'(len), 64'(model[2][s][31:0]), "pulse width");
      end
      // page 0 named here, so only the running set can answer with page 2 values
      host_write(`PULSE_ADDR_CTRL, ctrl_word(1'b0, 1'b1, 2'd0, 32'd400));
      for (int c = 0; c < `PULSE_N_CHANNELS; c++) begin
         host_read(`PULSE_ADDR_CH0 + 4'(c), word);
         check_equal(word, model[2][c], "active set readback");
      end
      end_test("commit_timing", e0);
   endtask

   task automatic test_eject_union();
      int          e0;
      int          offset;
      int          len;
      logic [31:0] d2;
      logic [31:0] w2;
      logic [31:0] d3;
      logic [31:0] w3;
      logic [31:0] stop;
      e0 = errors;
      d2   = 32'd10 + random_below(32'd50);
      w2   = 32'd20 + random_below(32'd40);
      d3   = d2 + w2 / 2;   // starts inside the first window
      w3   = 32'd5 + random_below(32'd60);
      stop = (d2 + w2 > d3 + w3) ? d2 + w2 : d3 + w3;
      host_write(`PULSE_ADDR_CTRL, ctrl_word(1'b0, 1'b0, 2'd1, 32'd400));
      host_write(`PULSE_ADDR_CH0 + 4'd2, {d2, w2});
      host_write(`PULSE_ADDR_CH0 + 4'd3, {d3, w3});
      host_write(`PULSE_ADDR_CTRL, ctrl_word(1'b1, 1'b0, 2'd1, 32'd400));
      measure_pulse(2, offset, len);
      check_equal(64'(offset), 64'(d2), "eject start");
      check_equal(64'(len), 64'(stop - d2), "eject length over both windows");
      end_test("eject_union", e0);
   endtask

   task automatic test_min_interval();
      int          e0;
      int          period;
      logic        saw_low;
      logic [63:0] first;
      logic [63:0] second;
      e0 = errors;
      host_write(`PULSE_ADDR_CTRL, ctrl_word(1'b1, 1'b0, 2'd1, 32'd10));
      measure_period(period, saw_low);
      check_equal(64'(period), 64'(`PULSE_MIN_INTERVAL), "clamped t0 period");
      check_equal(64'(saw_low), 64'd1, "eject active in short period");
      wait_t0_rise(500);
      host_read(`PULSE_ADDR_T0COUNT, first);
      for (int k = 0; k < 3; k++) begin
         wait_t0_rise(500);
      end
      host_read(`PULSE_ADDR_T0COUNT, second);
      check_equal(second - first, 64'd3, "t0 count step");
      wait_t0_rise(500);
      host_read(`PULSE_ADDR_STAMP, first);
      wait_t0_rise(500);
      host_read(`PULSE_ADDR_STAMP, second);
      check_equal(second - first, 64'(`PULSE_MIN_INTERVAL), "timestamp step");
      end_test("min_interval", e0);
   endtask

   initial begin
      host_req         = '0;
      hps_fpga_reset_n = 1'b0;
      repeat (4) @(posedge clk100);
      #1;
      hps_fpga_reset_n = 1'b1;
      test_reset_idle();
      test_page_readback();
      test_commit_timing();
      test_eject_union();
      test_min_interval();
      $display("tests 5, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+include
hw/pulse_pkg.sv
hw/protocol_regs.sv
hw/period_timer.sv
hw/delay_channel.sv
hw/pulse_outputs.sv
hw/delay_generator_top.sv
tests/tb_delay_generator.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it, and exits non-zero unless the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_delay_generator -f sources.f -o tb_delay_generator || exit 1
./obj_dir/tb_delay_generator | tee /dev/stderr | grep -qxF '** PASS **' \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
